// ==== hw/cache_pkg.sv ====
package cache_pkg;

  // ==============================
  // cache geometry
  // ==============================
  localparam int TAG_WIDTH      = 26;
  localparam int INDEX_WIDTH    = 2;
  localparam int OFFSET_WIDTH   = 4;  // byte offset inside a line.
  localparam int WORDS_PER_LINE = 4;
  localparam int NUM_SETS       = 4;

  // Field view of a byte address, from tag down to byte offset.
  typedef struct packed {
    logic [TAG_WIDTH-1:0]      tag;
    logic [INDEX_WIDTH-1:0]    index;
    logic [OFFSET_WIDTH-3:0]   word_off;
    logic [1:0]                byte_off;
  } cache_addr_fields_t;

  typedef union packed {
    logic [31:0]        raw;
    cache_addr_fields_t f;
  } cache_addr_u;

  // ==============================
  // port requests
  // ==============================
  typedef struct packed {
    logic        write;
    cache_addr_u addr;
    logic [31:0] wdata;
  } cpu_req_t;

  typedef struct packed {
    logic        write;
    logic [31:0] addr;   // always word aligned.
    logic [31:0] wdata;
  } mem_req_t;

endpackage

// ==== hw/cache_ctrl_pkg.sv ====
package cache_ctrl_pkg;

  // Control word broadcast from the controller to every set.
  typedef struct packed {
    logic write_en;
    logic set_valid;
    logic set_dirty;
    logic strategy_en;  // victim choice may follow the age state.
    logic offset_sel;   // 1 takes offset and data from the processor side.
  } set_ctrl_t;

  // ==============================
  // miss handling FSM
  // ==============================
  typedef enum logic [2:0] {
    IDLE,
    COMPARE,
    WRITEBACK,
    REFILL,
    RESPOND
  } ctrl_state_e;

endpackage

// ==== hw/cache_line.sv ====
`timescale 1ns/1ps

module cache_line import cache_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    write_en_i,
  input  logic                    set_valid_i,
  input  logic                    set_dirty_i,
  input  logic [TAG_WIDTH-1:0]    set_tag_i,
  input  logic [OFFSET_WIDTH-3:0] offset_i,
  input  logic [31:0]             write_data_i,
  output logic                    valid_o,
  output logic                    dirty_o,
  output logic [TAG_WIDTH-1:0]    tag_o,
  output logic                    hit_o,
  output logic [31:0]             read_data_o
);

  logic                 valid_q;
  logic                 dirty_q;
  logic [TAG_WIDTH-1:0] tag_q;
  logic [31:0]          data_q [WORDS_PER_LINE];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      dirty_q <= 1'b0;
    end else if (write_en_i) begin
      valid_q <= set_valid_i;
      dirty_q <= set_dirty_i;
    end
  end

  // The tag only matters once the line is valid.
  always_ff @(posedge clk_i) begin
    if (write_en_i) begin
      tag_q            <= set_tag_i;
      data_q[offset_i] <= write_data_i;  // one word per write.
    end
  end

  assign valid_o     = valid_q;
  assign dirty_o     = dirty_q;
  assign tag_o       = tag_q;
  assign hit_o       = valid_q && (tag_q == set_tag_i);
  assign read_data_o = data_q[offset_i];

endmodule

// ==== hw/replace_controller.sv ====
`timescale 1ns/1ps

module replace_controller #(
  parameter  int NUM_WAYS = 2,
  localparam int WAY_W    = $clog2(NUM_WAYS)
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             strategy_en_i,
  input  logic             write_en_i,
  input  logic [WAY_W-1:0] line_write_i,
  output logic [WAY_W-1:0] line_replace_o
);

  logic [WAY_W-1:0] age_q [NUM_WAYS];
  logic [WAY_W-1:0] written_age;

  assign written_age = age_q[line_write_i];

  // The written way becomes the youngest.
  // Ways at or below its old age step back by one, saturating at the oldest slot,
  // so the all-zero reset state settles into a strict order.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_WAYS; i++) begin
        age_q[i] <= '0;
      end
    end else if (write_en_i) begin
      for (int i = 0; i < NUM_WAYS; i++) begin
        if (WAY_W'(i) == line_write_i) begin
          age_q[i] <= '0;
        end else if (age_q[i] <= written_age && age_q[i] != WAY_W'(NUM_WAYS - 1)) begin
          age_q[i] <= age_q[i] + 1'b1;
        end
      end
    end
  end

  always_comb begin
    logic [WAY_W-1:0] oldest;
    oldest = '0;
    if (strategy_en_i) begin
      for (int i = NUM_WAYS - 1; i >= 0; i--) begin
        if (age_q[i] >= age_q[oldest]) begin
          oldest = WAY_W'(i);  // ties go to the lowest way.
        end
      end
    end
    line_replace_o = oldest;
  end

  // The way that was just written is never the next victim.
  a_victim_not_newest: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    write_en_i |=> !strategy_en_i || line_replace_o != $past(line_write_i));

endmodule

// ==== hw/cache_set.sv ====
`timescale 1ns/1ps

module cache_set import cache_pkg::*; import cache_ctrl_pkg::*; #(
  parameter  int NUM_WAYS = 2,
  localparam int WAY_W    = $clog2(NUM_WAYS)
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  set_ctrl_t            set_ctrl_i,
  input  cache_addr_u          addr_i,
  input  logic [31:0]          write_data_i,
  input  logic [31:0]          mem_addr_i,
  input  logic [31:0]          mem_read_data_i,
  output logic                 hit_o,
  output logic                 dirty_o,
  output logic [TAG_WIDTH-1:0] tag_dirty_line_o,
  output logic [31:0]          read_data_o
);

  logic [OFFSET_WIDTH-3:0] offset;
  logic [31:0]             write_data;
  logic                    all_valid;
  logic [NUM_WAYS-1:0]     valid_line;
  logic [NUM_WAYS-1:0]     dirty_line;
  logic [NUM_WAYS-1:0]     hit_line;
  logic [NUM_WAYS-1:0]     write_en_line;
  logic [TAG_WIDTH-1:0]    tag_line [NUM_WAYS];
  logic [31:0]             read_data_line [NUM_WAYS];
  logic [WAY_W-1:0]        line_replace;
  logic [WAY_W-1:0]        hit_way;
  logic [WAY_W-1:0]        victim_way;
  logic [WAY_W-1:0]        write_way;

  // the refill counter supplies the word during write-back and refill.
  assign offset     = set_ctrl_i.offset_sel ? addr_i.f.word_off : mem_addr_i[OFFSET_WIDTH-1:2];
  assign write_data = set_ctrl_i.offset_sel ? write_data_i : mem_read_data_i;
  assign all_valid  = &valid_line;
  assign hit_o      = |hit_line;

  replace_controller #(
    .NUM_WAYS(NUM_WAYS)
  ) u_replace_controller (
    .clk_i,
    .rst_n_i,
    .strategy_en_i (set_ctrl_i.strategy_en & all_valid),
    .write_en_i    (set_ctrl_i.write_en),
    .line_write_i  (write_way),
    .line_replace_o(line_replace)
  );

  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_line
    cache_line u_line (
      .clk_i,
      .rst_n_i,
      .write_en_i  (write_en_line[w]),
      .set_valid_i (set_ctrl_i.set_valid),
      .set_dirty_i (set_ctrl_i.set_dirty),
      .set_tag_i   (addr_i.f.tag),
      .offset_i    (offset),
      .write_data_i(write_data),
      .valid_o     (valid_line[w]),
      .dirty_o     (dirty_line[w]),
      .tag_o       (tag_line[w]),
      .hit_o       (hit_line[w]),
      .read_data_o (read_data_line[w])
    );
  end

  // ==============================
  // way selection
  // ==============================
  always_comb begin
    hit_way    = '0;
    victim_way = line_replace;
    for (int i = 0; i < NUM_WAYS; i++) begin
      if (hit_line[i]) begin
        hit_way = WAY_W'(i);
      end
    end
    // The lowest invalid way is used before anything is evicted.
    for (int i = NUM_WAYS - 1; i >= 0; i--) begin
      if (!valid_line[i]) begin
        victim_way = WAY_W'(i);
      end
    end
    write_way                = hit_o ? hit_way : victim_way;
    write_en_line            = '0;
    write_en_line[write_way] = set_ctrl_i.write_en;
  end

  assign dirty_o          = dirty_line[victim_way];  // state of the line a miss replaces.
  assign tag_dirty_line_o = tag_line[victim_way];
  assign read_data_o      = hit_o ? read_data_line[hit_way] : read_data_line[victim_way];

  a_single_hit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(hit_line));

endmodule

// ==== hw/cache_controller.sv ====
`timescale 1ns/1ps

module cache_controller import cache_pkg::*; import cache_ctrl_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 cpu_req_valid_i,
  input  cpu_req_t             cpu_req_i,
  input  logic                 hit_i,
  input  logic                 dirty_i,
  input  logic [TAG_WIDTH-1:0] victim_tag_i,
  input  logic [31:0]          set_rdata_i,
  input  logic                 mem_ack_i,
  input  logic [31:0]          mem_rdata_i,
  output cpu_req_t             req_o,
  output set_ctrl_t            set_ctrl_o,
  output logic [31:0]          refill_addr_o,
  output logic                 busy_o,
  output logic                 cpu_ready_o,
  output logic [31:0]          cpu_rdata_o,
  output logic                 mem_req_o,
  output mem_req_t             mem_req_data_o
);

  localparam logic [OFFSET_WIDTH-3:0] LAST_WORD = (OFFSET_WIDTH - 2)'(WORDS_PER_LINE - 1);

  ctrl_state_e             state_q;
  cpu_req_t                req_q;
  logic [OFFSET_WIDTH-3:0] word_cnt_q;
  logic                    mem_req_q;
  logic                    mem_done;
  logic                    cpu_ready_q;
  logic [31:0]             cpu_rdata_q;
  cache_addr_u             word_addr;

  assign mem_done = mem_req_q && mem_ack_i;  // the current word is finished.

  // ==============================
  // state and control registers
  // ==============================
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      word_cnt_q  <= '0;
      mem_req_q   <= 1'b0;
      cpu_ready_q <= 1'b0;
    end else begin
      cpu_ready_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (cpu_req_valid_i) begin
            state_q <= COMPARE;
          end
        end
        COMPARE: begin
          word_cnt_q <= '0;
          if (hit_i) begin
            state_q <= RESPOND;
          end else if (dirty_i) begin
            state_q <= WRITEBACK;
          end else begin
            state_q <= REFILL;
          end
        end
        WRITEBACK, REFILL: begin
          if (!mem_req_q) begin
            mem_req_q <= 1'b1;  // raise the request for the next word.
          end else if (mem_ack_i) begin
            mem_req_q  <= 1'b0;
            word_cnt_q <= word_cnt_q + 1'b1;
            if (word_cnt_q == LAST_WORD) begin
              // a refilled line hits on the second compare.
              state_q <= (state_q == WRITEBACK) ? REFILL : COMPARE;
            end
          end
        end
        RESPOND: begin
          cpu_ready_q <= 1'b1;
          state_q     <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && cpu_req_valid_i) begin
      req_q <= cpu_req_i;
    end
    if (state_q == RESPOND) begin
      cpu_rdata_q <= set_rdata_i;  // for a write this is the word just stored.
    end
  end

  // ==============================
  // set control and memory request
  // ==============================
  always_comb begin
    set_ctrl_o = '0;
    case (state_q)
      COMPARE: begin
        set_ctrl_o.strategy_en = 1'b1;
        set_ctrl_o.offset_sel  = 1'b1;
        if (hit_i && req_q.write) begin
          set_ctrl_o.write_en  = 1'b1;
          set_ctrl_o.set_valid = 1'b1;
          set_ctrl_o.set_dirty = 1'b1;
        end
      end
      WRITEBACK: set_ctrl_o.strategy_en = 1'b1;
      REFILL: begin
        set_ctrl_o.strategy_en = 1'b1;
        set_ctrl_o.write_en    = mem_done;
        set_ctrl_o.set_valid   = 1'b1;
      end
      RESPOND: set_ctrl_o.offset_sel = 1'b1;
      default: ;
    endcase
  end

  always_comb begin
    word_addr.f.tag      = (state_q == WRITEBACK) ? victim_tag_i : req_q.addr.f.tag;
    word_addr.f.index    = req_q.addr.f.index;
    word_addr.f.word_off = word_cnt_q;
    word_addr.f.byte_off = 2'b00;
    mem_req_data_o.write = (state_q == WRITEBACK);
    mem_req_data_o.addr  = word_addr.raw;
    mem_req_data_o.wdata = (state_q == WRITEBACK) ? set_rdata_i : '0;
  end

  assign req_o         = req_q;
  assign refill_addr_o = word_addr.raw;
  assign busy_o        = (state_q != IDLE);
  assign cpu_ready_o   = cpu_ready_q;
  assign cpu_rdata_o   = cpu_rdata_q;
  assign mem_req_o     = mem_req_q;

  a_mem_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_o && !mem_ack_i |=> $stable(mem_req_data_o));

endmodule

// ==== hw/cache_top.sv ====
`timescale 1ns/1ps

module cache_top import cache_pkg::*; import cache_ctrl_pkg::*; #(
  parameter int NUM_WAYS = 2
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        cpu_req_valid_i,
  input  cpu_req_t    cpu_req_i,
  output logic        busy_o,
  output logic        cpu_ready_o,
  output logic [31:0] cpu_rdata_o,
  output logic        mem_req_o,
  output mem_req_t    mem_req_data_o,
  input  logic        mem_ack_i,
  input  logic [31:0] mem_rdata_i
);

  cpu_req_t               req;
  set_ctrl_t              set_ctrl;
  logic [31:0]            refill_addr;
  logic [INDEX_WIDTH-1:0] index;
  logic [NUM_SETS-1:0]    hit_set;
  logic [NUM_SETS-1:0]    dirty_set;
  logic [TAG_WIDTH-1:0]   victim_tag_set [NUM_SETS];
  logic [31:0]            rdata_set [NUM_SETS];

  assign index = req.addr.f.index;

  // ==============================
  // set array
  // ==============================
  for (genvar s = 0; s < NUM_SETS; s++) begin : g_set
    set_ctrl_t ctrl_gated;

    always_comb begin
      ctrl_gated          = set_ctrl;
      // only the indexed set writes.
      ctrl_gated.write_en = set_ctrl.write_en && (index == INDEX_WIDTH'(s));
    end

    cache_set #(
      .NUM_WAYS(NUM_WAYS)
    ) u_set (
      .clk_i,
      .rst_n_i,
      .set_ctrl_i      (ctrl_gated),
      .addr_i          (req.addr),
      .write_data_i    (req.wdata),
      .mem_addr_i      (refill_addr),
      .mem_read_data_i (mem_rdata_i),
      .hit_o           (hit_set[s]),
      .dirty_o         (dirty_set[s]),
      .tag_dirty_line_o(victim_tag_set[s]),
      .read_data_o     (rdata_set[s])
    );
  end

  cache_controller u_controller (
    .clk_i,
    .rst_n_i,
    .cpu_req_valid_i,
    .cpu_req_i,
    .hit_i         (hit_set[index]),
    .dirty_i       (dirty_set[index]),
    .victim_tag_i  (victim_tag_set[index]),
    .set_rdata_i   (rdata_set[index]),
    .mem_ack_i,
    .mem_rdata_i,
    .req_o         (req),
    .set_ctrl_o    (set_ctrl),
    .refill_addr_o (refill_addr),
    .busy_o,
    .cpu_ready_o,
    .cpu_rdata_o,
    .mem_req_o,
    .mem_req_data_o
  );

endmodule

// ==== verification/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb import cache_pkg::*; ();

  localparam int          CLK_PERIOD   = 40;
  localparam int          RESET_CYCLES = 8;
  localparam int          MEM_WORDS    = 128;  // tags 0 to 7 fit in the model.
  localparam int          NUM_ACCESSES = 60;   // upper bound on processor accesses below.
  localparam int          MISS_CYCLES  = 60;   // write-back plus refill at the longest latency.
  localparam logic [31:0] LFSR_SEED    = 32'h0f54869c;

  logic        clk_i;
  logic        rst_n_i;
  logic        cpu_req_valid_i;
  cpu_req_t    cpu_req_i;
  logic        busy_o;
  logic        cpu_ready_o;
  logic [31:0] cpu_rdata_o;
  logic        mem_req_o;
  mem_req_t    mem_req_data_o;
  logic        mem_ack_i;
  logic [31:0] mem_rdata_i;

  logic [31:0] mem_words [MEM_WORDS];  // contents of the external memory.
  logic [31:0] shadow [MEM_WORDS];     // the value every address should hold.
  logic [31:0] lat_lfsr;
  logic [31:0] stim_lfsr;
  logic [27:0] watch_line;
  int          mem_reads;
  int          mem_writes;
  int          mem_req_cycles;
  int          watch_reads;
  int          watch_writes;

  cache_top #(
    .NUM_WAYS(2)
  ) DUT (
    .clk_i,
    .rst_n_i,
    .cpu_req_valid_i,
    .cpu_req_i,
    .busy_o,
    .cpu_ready_o,
    .cpu_rdata_o,
    .mem_req_o,
    .mem_req_data_o,
    .mem_ack_i,
    .mem_rdata_i
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ==============================
  // helpers
  // ==============================
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic draw_bits(inout logic [31:0] state, input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      state = lfsr_step(state);
      value = {value[30:0], state[0]};  // one step per bit.
    end
  endtask

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e3779b9) ^ {addr[15:0], ~addr[15:0]};
  endfunction

  function automatic logic [31:0] make_addr(input logic [TAG_WIDTH-1:0] tag,
                                            input logic [INDEX_WIDTH-1:0] index,
                                            input logic [1:0] word);
    return {tag, index, word, 2'b00};
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // ==============================
  // memory model
  // ==============================
  task automatic serve_memory();
    logic [6:0] w;
    if (mem_req_data_o.addr[31:9] != '0 || mem_req_data_o.addr[1:0] != 2'b00) begin
      $display("memory request to address %h lies outside the memory model",
               mem_req_data_o.addr);
      $display("Simulation failed");
      $fatal(1, "bad memory address");
    end else begin
      w = mem_req_data_o.addr[8:2];
      if (mem_req_data_o.write) begin
        mem_words[w] = mem_req_data_o.wdata;
        mem_writes++;
        if (mem_req_data_o.addr[31:4] == watch_line) watch_writes++;
      end else begin
        mem_rdata_i = mem_words[w];
        mem_reads++;
        if (mem_req_data_o.addr[31:4] == watch_line) watch_reads++;
      end
    end
  endtask

  // Answers each request after 1 to 4 cycles with a one-cycle acknowledge.
  initial begin : memory_model
    int          lat_left;
    logic [31:0] lat_bits;
    mem_ack_i   = 1'b0;
    mem_rdata_i = '0;
    lat_left    = 1;
    forever begin
      @(negedge clk_i);
      if (mem_req_o) mem_req_cycles++;
      if (mem_ack_i) begin
        mem_ack_i = 1'b0;  // the request drops after an acknowledge.
      end else if (mem_req_o) begin
        if (lat_left > 1) begin
          lat_left--;
        end else begin
          serve_memory();
          mem_ack_i = 1'b1;
          draw_bits(lat_lfsr, 2, lat_bits);
          lat_left = int'(lat_bits[1:0]) + 1;
        end
      end
    end
  end

  // ==============================
  // processor accesses
  // ==============================
  task automatic cpu_access(input logic write, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output int cycles);
    @(negedge clk_i);
    check_value("busy before a request", 32'(busy_o), 32'd0);
    cpu_req_i.write    = write;
    cpu_req_i.addr.raw = addr;
    cpu_req_i.wdata    = wdata;
    cpu_req_valid_i    = 1'b1;
    @(negedge clk_i);
    cpu_req_valid_i = 1'b0;
    cycles          = 0;  // counts edges after the one that took the request.
    while (!cpu_ready_o) begin
      @(negedge clk_i);
      cycles++;
    end
    rdata = cpu_rdata_o;
  endtask

  task automatic read_and_compare(input logic [31:0] addr, output int cycles);
    logic [31:0] rdata;
    cpu_access(1'b0, addr, '0, rdata, cycles);
    check_value($sformatf("read of %h", addr), rdata, shadow[addr[8:2]]);
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    int          cycles;
    cpu_access(1'b1, addr, data, rdata, cycles);
    check_value($sformatf("write echo of %h", addr), rdata, data);
    shadow[addr[8:2]] = data;
  endtask

  // ==============================
  // directed tests
  // ==============================
  task automatic read_miss_fetches_line();
    int reads0;
    int writes0;
    int cycles;
    reads0      = mem_reads;
    writes0     = mem_writes;
    watch_line  = 28'(make_addr(1, 1, 0) >> 4);
    watch_reads = 0;
    read_and_compare(make_addr(1, 1, 2), cycles);
    check_value("memory reads on a clean miss", 32'(mem_reads - reads0), 32'd4);
    check_value("reads of the missed line", 32'(watch_reads), 32'd4);
    check_value("memory writes on a clean miss", 32'(mem_writes - writes0), 32'd0);
  endtask

  task automatic read_hit_skips_memory();
    int req0;
    int cycles;
    req0 = mem_req_cycles;
    read_and_compare(make_addr(1, 1, 0), cycles);
    check_value("read hit latency", 32'(cycles), 32'd2);
    check_value("memory requests on a hit", 32'(mem_req_cycles - req0), 32'd0);
  endtask

  task automatic write_hit_stays_in_cache();
    logic [31:0] addr;
    int          cycles;
    addr = make_addr(1, 1, 1);
    write_word(addr, 32'hcafe_0001);
    read_and_compare(addr, cycles);
    // write-back leaves the memory copy untouched until eviction.
    check_value("memory after a write hit", mem_words[addr[8:2]], fill_word(addr));
  endtask

  task automatic eviction_writes_back();
    logic [31:0] line_addr;
    int          reads0;
    int          writes0;
    int          cycles;
    write_word(make_addr(1, 1, 0), 32'hcafe_0000);
    write_word(make_addr(1, 1, 2), 32'hcafe_0002);
    write_word(make_addr(1, 1, 3), 32'hcafe_0003);
    read_and_compare(make_addr(2, 1, 0), cycles);  // fills the second way, tag 1 is now oldest.
    reads0       = mem_reads;
    writes0      = mem_writes;
    watch_line   = 28'(make_addr(1, 1, 0) >> 4);
    watch_writes = 0;
    read_and_compare(make_addr(3, 1, 3), cycles);
    check_value("write-back words of the victim", 32'(watch_writes), 32'd4);
    check_value("memory writes on a dirty miss", 32'(mem_writes - writes0), 32'd4);
    check_value("memory reads on a dirty miss", 32'(mem_reads - reads0), 32'd4);
    for (int w = 0; w < 4; w++) begin
      line_addr = make_addr(1, 1, 2'(w));
      check_value($sformatf("memory word %0d after write-back", w),
                  mem_words[line_addr[8:2]], shadow[line_addr[8:2]]);
    end
    read_and_compare(make_addr(2, 1, 1), cycles);
    check_value("younger line kept", 32'(cycles), 32'd2);
  endtask

  task automatic random_mix_matches_shadow();
    logic [31:0]          r;
    logic [31:0]          data;
    logic [TAG_WIDTH-1:0] tag;
    logic [31:0]          addr;
    logic                 write;
    int                   cycles;
    for (int n = 0; n < 40; n++) begin
      draw_bits(stim_lfsr, 1, r);
      write = r[0];
      draw_bits(stim_lfsr, 2, r);
      tag = TAG_WIDTH'(r % 32'd3 + 32'd1);
      draw_bits(stim_lfsr, 4, r);
      addr = make_addr(tag, r[3:2], r[1:0]);
      if (write) begin
        draw_bits(stim_lfsr, 32, data);
        write_word(addr, data);
      end else begin
        read_and_compare(addr, cycles);
      end
    end
  endtask

  // ==============================
  // run control
  // ==============================
  initial begin : watchdog
    #(CLK_PERIOD * (RESET_CYCLES + NUM_ACCESSES * MISS_CYCLES));
    $display("timeout: the tests did not finish in the expected time");
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

  initial begin : main
    rst_n_i         = 1'b0;
    cpu_req_valid_i = 1'b0;
    cpu_req_i       = '0;
    lat_lfsr        = LFSR_SEED;
    stim_lfsr       = LFSR_SEED;
    watch_line      = '1;
    mem_reads       = 0;
    mem_writes      = 0;
    mem_req_cycles  = 0;
    watch_reads     = 0;
    watch_writes    = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_words[i] = fill_word(32'(i) << 2);
      shadow[i]    = mem_words[i];
    end
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_n_i = 1'b1;

    read_miss_fetches_line();
    read_hit_skips_memory();
    write_hit_stays_in_cache();
    eviction_writes_back();
    random_mix_matches_shadow();

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== cache_top.f ====
hw/cache_pkg.sv
hw/cache_ctrl_pkg.sv
hw/cache_line.sv
hw/replace_controller.sv
hw/cache_set.sv
hw/cache_controller.sv
hw/cache_top.sv
verification/cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the cache testbench with Verilator and run it.
# The exit status of the simulation is the exit status of this script.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module cache_tb \
  -f cache_top.f \
  -o cache_tb_sim

./obj_dir/cache_tb_sim
